// ==== src.f ====
rtl/riscv_pkg.sv
rtl/exec_pkg.sv
rtl/alu_ctrl_decoder.sv
rtl/int_regfile.sv
rtl/muldiv_unit.sv
rtl/alu_pipe.sv
rtl/int_exec_top.sv
verif/exec_checker.sv
verif/tb_int_exec.sv

// ==== Makefile ====
# Verilator build and run of the integer execution testbench

VERILATOR ?= verilator
TOP       ?= tb_int_exec
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
PASS_MSG  ?= Testbench passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_int_exec.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_int_exec;
  import riscv_pkg::*;
  import exec_pkg::*;

  localparam int WORST_LAT   = XLEN_W + XLEN_W / MUL_UNROLL + 4;   // 40 cycles
  localparam int INST_BUDGET = 800;

  logic             clk;
  logic             reset_n;
  issue_t           issue;
  logic             busy;
  wb_t              wb;
  logic [31:0]      rnd;
  pc_t              pc;
  logic [TAG_W-1:0] tag;
  int               errors;
  int               checks;
  int               pending;
  int               err_mark;
  reg_idx_t         prev1;
  reg_idx_t         prev2;
  reg_idx_t         rd;
  logic [31:0]      r;

  int_exec_top UUT (
    .i_clk     (clk),
    .i_reset_n (reset_n),
    .i_issue   (issue),
    .o_busy    (busy),
    .o_wb      (wb)
  );

  exec_checker u_checker (
    .i_clk     (clk),
    .i_reset_n (reset_n),
    .i_issue   (issue),
    .i_busy    (busy),
    .i_wb      (wb),
    .o_errors  (errors),
    .o_checks  (checks),
    .o_pending (pending)
  );

  always #2 clk = ~clk;

  function logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] rand32();
    rnd = xorshift(rnd);
    return rnd;
  endfunction

  function logic [31:0] rtype_word(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3,
                                   input reg_idx_t rd_i);
    return {f7, rs2, rs1, f3, rd_i, OPC_OP};
  endfunction

  function logic [31:0] itype_word(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd_i);
    return {imm, rs1, f3, rd_i, OPC_OP_IMM};
  endfunction

  function logic [31:0] utype_word(input logic [19:0] imm, input reg_idx_t rd_i,
                                   input logic [6:0] opc);
    return {imm, rd_i, opc};
  endfunction

  // ----------------------------------------------------------------------
  // Issue driving
  // ----------------------------------------------------------------------
  task automatic issue_inst(input logic [31:0] ins);
    @(posedge clk);
    issue.valid <= 1'b1;
    issue.inst  <= ins;
    issue.pc    <= pc;
    issue.tag   <= tag;
    pc  = pc + 4;
    tag = tag + 1'b1;
    if (ins[6:0] == OPC_OP && ins[31:25] == F7_MULDIV) begin
      @(posedge clk);
      issue.valid <= 1'b0;
      do @(posedge clk); while (busy);   // Hold off until the unit is free
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      issue.valid <= 1'b0;
    end
  endtask

  task automatic finish_test(input string name);
    idle(1);
    do @(negedge clk); while (pending != 0 || busy);
    $display("test %s done, %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  task automatic load_operands();
    issue_inst(utype_word(20'h80000, 5'd1, OPC_LUI));
    issue_inst(itype_word(12'hfff, 5'd0, 3'd0, 5'd2));   // -1
    issue_inst(utype_word(20'(rand32()), 5'd3, OPC_LUI));
    issue_inst(itype_word(12'(rand32()), 5'd3, 3'd4, 5'd3));
    issue_inst(utype_word(20'(rand32()), 5'd4, OPC_LUI));
    issue_inst(itype_word(12'(rand32()), 5'd4, 3'd4, 5'd4));
    issue_inst(itype_word(12'h001, 5'd0, 3'd0, 5'd5));
    issue_inst(utype_word(20'h80000, 5'd6, OPC_LUI));
    issue_inst(itype_word(12'hfff, 5'd6, 3'd0, 5'd6));   // 0x7fffffff
  endtask

  task automatic muldiv_sweep(input logic [2:0] f3_lo);
    for (int f = 0; f < 4; f++) begin
      load_operands();
      for (int a = 0; a < 7; a++) begin
        for (int b = 0; b < 7; b++) begin
          r = rand32();
          issue_inst(rtype_word(F7_MULDIV, 5'(b), 5'(a), f3_lo + 3'(f), 5'(7 + r % 25)));
        end
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Watchdog
  // ----------------------------------------------------------------------
  initial begin
    #((8 + INST_BUDGET * WORST_LAT) * 4);
    $display("Timeout, the run did not finish in the expected time");
    $display("Testbench failed");
    $finish;
  end

  initial begin
    clk      = 1'b0;
    reset_n  = 1'b0;
    issue    = '0;
    rnd      = 32'hdf8e;
    pc       = 32'h0000_1000;
    tag      = '0;
    err_mark = 0;
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;
    idle(4);

    for (int i = 1; i < 32; i++) begin
      issue_inst(itype_word(12'h000, 5'(i), 3'd0, 5'(i)));
    end
    finish_test("reset");

    for (int i = 1; i < 32; i += 4) begin
      issue_inst(utype_word(20'(rand32()), 5'(i), OPC_LUI));
      issue_inst(itype_word(12'(rand32()), 5'(i), 3'd6, 5'(i)));
    end
    for (int i = 0; i < 60; i++) begin
      r = rand32();
      issue_inst(rtype_word((r[3] && (r[2:0] == 0 || r[2:0] == 5)) ? F7_ALT : F7_BASE,
                            r[12:8], r[17:13], r[2:0], r[22:18]));   // rd may be x0
    end
    finish_test("reg_reg");

    for (int i = 0; i < 60; i++) begin
      r = rand32();
      if (r[1:0] == 0) begin
        issue_inst(utype_word(20'(rand32()), r[9:5], OPC_LUI));
      end else if (r[1:0] == 1) begin
        issue_inst(utype_word(20'(rand32()), r[9:5], OPC_AUIPC));
      end else if (r[4:2] == 1) begin
        issue_inst(itype_word({F7_BASE, r[14:10]}, r[19:15], 3'd1, r[9:5]));
      end else if (r[4:2] == 5) begin
        issue_inst(itype_word({r[20] ? F7_ALT : F7_BASE, r[14:10]}, r[19:15], 3'd5, r[9:5]));
      end else begin
        issue_inst(itype_word(r[31:20], r[19:15], r[4:2], r[9:5]));
      end
    end
    finish_test("imm");

    // Chains at distance one, then two, then with a gap
    prev1 = 5'd1;
    prev2 = 5'd2;
    for (int i = 0; i < 50; i++) begin
      r  = rand32();
      rd = (r[4:0] == 0) ? 5'd7 : r[4:0];
      issue_inst(rtype_word(F7_BASE, r[9:5], (i >= 20 && i < 40) ? prev2 : prev1,
                            r[12:10], rd));
      if (i >= 40) begin
        idle(1);
      end
      prev2 = prev1;
      prev1 = rd;
    end
    finish_test("chain");

    muldiv_sweep(3'd0);
    finish_test("mul");
    muldiv_sweep(3'd4);
    finish_test("div");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/exec_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_checker (
  input  wire logic             i_clk,
  input  wire logic             i_reset_n,
  input  wire exec_pkg::issue_t i_issue,
  input  wire logic             i_busy,
  input  wire exec_pkg::wb_t    i_wb,
  output int                    o_errors,
  output int                    o_checks,
  output int                    o_pending
);
  import riscv_pkg::*;
  import exec_pkg::*;

  typedef struct packed {
    logic             md;
    reg_idx_t         rd;
    data_t            data;
    logic [TAG_W-1:0] tag;
  } expect_t;

  expect_t exp_q[$];
  data_t   model_regs [32];
  logic    seen_issue;
  logic    md_open;   // Muldiv issued, result not seen yet

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic data_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input data_t a, input data_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? data_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic data_t muldiv_ref(input logic [2:0] f3, input data_t a, input data_t b);
    logic [63:0] x;
    logic [63:0] y;
    logic [63:0] p;
    logic        ovf;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    x = (f3 == 3'd3) ? {32'd0, a} : {{32{a[31]}}, a};
    y = (f3 == 3'd1) ? {{32{b[31]}}, b} : {32'd0, b};
    p = x * y;   // Product modulo 2^64
    case (f3)
      3'd0:    return p[31:0];
      3'd1,
      3'd2,
      3'd3:    return p[63:32];
      3'd4:    return (b == 0) ? 32'hffff_ffff : ovf ? a : data_t'($signed(a) / $signed(b));
      3'd5:    return (b == 0) ? 32'hffff_ffff : a / b;
      3'd6:    return (b == 0) ? a : ovf ? 32'd0 : data_t'($signed(a) % $signed(b));
      default: return (b == 0) ? a : a % b;
    endcase
  endfunction

  function automatic data_t ref_result(input logic [31:0] ins, input pc_t pc,
                                       input data_t a, input data_t b);
    data_t imm_i;
    data_t imm_u;
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_u = {ins[31:12], 12'h000};
    case (ins[6:0])
      OPC_LUI:    return imm_u;
      OPC_AUIPC:  return pc + imm_u;
      OPC_OP_IMM: begin
        if (ins[14:12] == 3'd1 || ins[14:12] == 3'd5) begin
          return alu_ref(ins[14:12], ins[30], a, {27'd0, ins[24:20]});
        end
        return alu_ref(ins[14:12], 1'b0, a, imm_i);
      end
      default: begin
        if (ins[31:25] == F7_MULDIV) begin
          return muldiv_ref(ins[14:12], a, b);
        end
        return alu_ref(ins[14:12], ins[30], a, b);
      end
    endcase
  endfunction

  initial begin
    o_errors   = 0;
    o_checks   = 0;
    o_pending  = 0;
    seen_issue = 1'b0;
    md_open    = 1'b0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
  end

  // ----------------------------------------------------------------------
  // Compare process
  // ----------------------------------------------------------------------
  always @(posedge i_clk) begin : compare_wb
    expect_t     e;
    logic [31:0] ins;
    data_t       res;
    if (i_reset_n) begin
      if (!seen_issue && (i_busy || i_wb.valid)) begin
        o_errors++;
        $display("Busy or a write-back showed up after reset before any issue");
      end
      if (i_wb.valid) begin
        if (exp_q.size() == 0) begin
          o_errors++;
          $display("Write-back to x%0d arrived with no instruction outstanding", i_wb.rd);
        end else begin
          e = exp_q.pop_front();
          o_checks++;
          if (i_wb.rd !== e.rd || i_wb.data !== e.data || i_wb.tag !== e.tag) begin
            o_errors++;
            $display("ERR %0t: x%0d tag %0h data %h, expected x%0d tag %0h data %h",
                     $time, i_wb.rd, i_wb.tag, i_wb.data, e.rd, e.tag, e.data);
          end
          if (e.md) begin
            md_open = 1'b0;
            if (i_busy) begin
              o_errors++;
              $display("Busy was still high when the muldiv write-back appeared");
            end
          end
        end
      end
      if (md_open && !i_busy) begin
        o_errors++;
        $display("Busy was low while a muldiv operation was still running");
      end
      if (i_issue.valid) begin
        seen_issue = 1'b1;
        ins = i_issue.inst;
        res = ref_result(ins, i_issue.pc, model_regs[ins[19:15]], model_regs[ins[24:20]]);
        if (ins[11:7] != 0) begin
          model_regs[ins[11:7]] = res;
          e.md   = (ins[6:0] == OPC_OP) && (ins[31:25] == F7_MULDIV);
          e.rd   = ins[11:7];
          e.data = res;
          e.tag  = i_issue.tag;
          exp_q.push_back(e);
          if (e.md) begin
            md_open = 1'b1;
          end
        end
      end
      o_pending = exp_q.size();
    end
  end

endmodule

`default_nettype wire

// ==== rtl/int_exec_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module int_exec_top (
  input  wire logic             i_clk,
  input  wire logic             i_reset_n,
  input  wire exec_pkg::issue_t i_issue,
  output logic                  o_busy,
  output exec_pkg::wb_t         o_wb
);
  import riscv_pkg::*;

  reg_idx_t w_rs1_addr;
  reg_idx_t w_rs2_addr;
  data_t    w_rs1_data;
  data_t    w_rs2_data;

  alu_pipe u_alu_pipe (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_issue    (i_issue),
    .o_rs1_addr (w_rs1_addr),
    .o_rs2_addr (w_rs2_addr),
    .i_rs1_data (w_rs1_data),
    .i_rs2_data (w_rs2_data),
    .i_fwd      (o_wb),          // Write-back loops into EX2
    .o_busy     (o_busy),
    .o_wb       (o_wb)
  );

  int_regfile u_regfile (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_rd_addr1 (w_rs1_addr),
    .i_rd_addr2 (w_rs2_addr),
    .o_rd_data1 (w_rs1_data),
    .o_rd_data2 (w_rs2_data),
    .i_wb       (o_wb)
  );

endmodule

`default_nettype wire

// ==== rtl/alu_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_pipe (
  input  wire logic                i_clk,
  input  wire logic                i_reset_n,
  input  wire exec_pkg::issue_t    i_issue,
  output riscv_pkg::reg_idx_t      o_rs1_addr,
  output riscv_pkg::reg_idx_t      o_rs2_addr,
  input  wire riscv_pkg::data_t    i_rs1_data,
  input  wire riscv_pkg::data_t    i_rs2_data,
  input  wire exec_pkg::wb_t       i_fwd,
  output logic                     o_busy,
  output exec_pkg::wb_t            o_wb
);
  import riscv_pkg::*;
  import exec_pkg::*;

  typedef struct packed {
    op_t  op;
    imm_t imm;
  } pipe_ctrl_t;

  pipe_ctrl_t       w_ex0_ctrl;
  logic             w_ex0_md;

  issue_t           r_ex1_issue;
  pipe_ctrl_t       r_ex1_ctrl;
  logic             r_ex1_md;     // Muldiv on its way, counts as busy

  issue_t           r_ex2_issue;
  pipe_ctrl_t       r_ex2_ctrl;
  logic             r_ex2_md;
  data_t            r_ex2_rs1;
  data_t            r_ex2_rs2;    // Register or immediate
  logic             w_ex2_fwd1;
  logic             w_ex2_fwd2;
  data_t            w_ex2_op1;
  data_t            w_ex2_op2;
  data_t            w_ex2_u_imm;
  data_t            w_ex2_result;
  logic             w_ex2_alu_wr;

  logic             r_ex3_valid;
  reg_idx_t         r_ex3_rd;
  logic [TAG_W-1:0] r_ex3_tag;
  data_t            r_ex3_result;

  logic             w_md_busy;
  wb_t              w_md_wb;

  // ----------------------------------------------------------------------
  // EX0
  // ----------------------------------------------------------------------
  alu_ctrl_decoder u_decoder (
    .i_inst (i_issue.inst),
    .o_op   (w_ex0_ctrl.op),
    .o_imm  (w_ex0_ctrl.imm)
  );

  assign w_ex0_md = i_issue.valid &
                    (w_ex0_ctrl.op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
                                           OP_DIV, OP_DIVU, OP_REM, OP_REMU});

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex1_ctrl  <= '0;
      r_ex1_md    <= 1'b0;
      r_ex2_issue <= '0;
      r_ex2_ctrl  <= '0;
      r_ex2_md    <= 1'b0;
      r_ex3_valid <= 1'b0;
    end else begin
      r_ex1_issue <= i_issue;
      r_ex1_ctrl  <= w_ex0_ctrl;
      r_ex1_md    <= w_ex0_md;
      r_ex2_issue <= r_ex1_issue;
      r_ex2_ctrl  <= r_ex1_ctrl;
      r_ex2_md    <= r_ex1_md;
      r_ex3_valid <= w_ex2_alu_wr;
    end
  end

  // ----------------------------------------------------------------------
  // EX1 register read and operand 2 select
  // ----------------------------------------------------------------------
  assign o_rs1_addr = r_ex1_issue.inst.r.rs1;
  assign o_rs2_addr = r_ex1_issue.inst.r.rs2;

  always_ff @(posedge i_clk) begin
    r_ex2_rs1 <= i_rs1_data;
    case (r_ex1_ctrl.imm)
      IMM_I:   r_ex2_rs2 <= {{(XLEN_W-12){r_ex1_issue.inst.r.funct7[6]}},
                             r_ex1_issue.inst.r.funct7, r_ex1_issue.inst.r.rs2};
      IMM_SH:  r_ex2_rs2 <= {{(XLEN_W-5){1'b0}}, r_ex1_issue.inst.r.rs2};
      default: r_ex2_rs2 <= i_rs2_data;
    endcase
    r_ex3_rd     <= r_ex2_issue.inst.r.rd;
    r_ex3_tag    <= r_ex2_issue.tag;
    r_ex3_result <= w_ex2_result;
  end

  // ----------------------------------------------------------------------
  // EX2 forward and compute
  // ----------------------------------------------------------------------
  assign w_ex2_fwd1 = i_fwd.valid & (i_fwd.rd == r_ex2_issue.inst.r.rs1) &
                      (r_ex2_issue.inst.r.rs1 != '0);
  assign w_ex2_fwd2 = i_fwd.valid & (r_ex2_ctrl.imm == IMM_NONE) &
                      (i_fwd.rd == r_ex2_issue.inst.r.rs2) & (r_ex2_issue.inst.r.rs2 != '0);
  assign w_ex2_op1  = w_ex2_fwd1 ? i_fwd.data : r_ex2_rs1;
  assign w_ex2_op2  = w_ex2_fwd2 ? i_fwd.data : r_ex2_rs2;

  assign w_ex2_u_imm  = {r_ex2_issue.inst.u.imm, 12'h000};
  assign w_ex2_alu_wr = r_ex2_issue.valid & ~r_ex2_md & (r_ex2_ctrl.op != OP_NOP) &
                        (r_ex2_issue.inst.r.rd != '0);

  always_comb begin
    case (r_ex2_ctrl.op)
      OP_ADD:   w_ex2_result = w_ex2_op1 + w_ex2_op2;
      OP_SUB:   w_ex2_result = w_ex2_op1 - w_ex2_op2;
      OP_SLL:   w_ex2_result = w_ex2_op1 << w_ex2_op2[4:0];
      OP_SLT:   w_ex2_result = {{(XLEN_W-1){1'b0}}, $signed(w_ex2_op1) < $signed(w_ex2_op2)};
      OP_SLTU:  w_ex2_result = {{(XLEN_W-1){1'b0}}, w_ex2_op1 < w_ex2_op2};
      OP_XOR:   w_ex2_result = w_ex2_op1 ^ w_ex2_op2;
      OP_SRL:   w_ex2_result = w_ex2_op1 >> w_ex2_op2[4:0];
      OP_SRA:   w_ex2_result = $signed(w_ex2_op1) >>> w_ex2_op2[4:0];
      OP_OR:    w_ex2_result = w_ex2_op1 | w_ex2_op2;
      OP_AND:   w_ex2_result = w_ex2_op1 & w_ex2_op2;
      OP_LUI:   w_ex2_result = w_ex2_u_imm;
      OP_AUIPC: w_ex2_result = r_ex2_issue.pc + w_ex2_u_imm;
      default:  w_ex2_result = '0;   // Muldiv and NOP
    endcase
  end

  muldiv_unit u_muldiv (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (r_ex2_md),
    .i_op      (r_ex2_ctrl.op),
    .i_rd      (r_ex2_issue.inst.r.rd),
    .i_tag     (r_ex2_issue.tag),
    .i_rs1     (w_ex2_op1),
    .i_rs2     (w_ex2_op2),
    .o_busy    (w_md_busy),
    .o_wb      (w_md_wb)
  );

  assign o_busy = w_md_busy | r_ex1_md | r_ex2_md;

  // ----------------------------------------------------------------------
  // EX3 result merge
  // ----------------------------------------------------------------------
  always_comb begin
    if (w_md_wb.valid) begin
      o_wb       = w_md_wb;
      o_wb.valid = (w_md_wb.rd != '0);
    end else begin
      o_wb.valid = r_ex3_valid;
      o_wb.rd    = r_ex3_rd;
      o_wb.data  = r_ex3_result;
      o_wb.tag   = r_ex3_tag;
    end
  end

  a_wb_exclusive: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(w_md_wb.valid && r_ex3_valid));

endmodule

`default_nettype wire

// ==== rtl/muldiv_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit (
  input  wire logic                       i_clk,
  input  wire logic                       i_reset_n,
  input  wire logic                       i_valid,
  input  wire exec_pkg::op_t              i_op,
  input  wire riscv_pkg::reg_idx_t        i_rd,
  input  wire logic [exec_pkg::TAG_W-1:0] i_tag,
  input  wire riscv_pkg::data_t           i_rs1,
  input  wire riscv_pkg::data_t           i_rs2,
  output logic                            o_busy,
  output exec_pkg::wb_t                   o_wb
);
  import riscv_pkg::*;
  import exec_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_MUL, ST_DIV, ST_DONE} state_t;

  state_t              r_state;
  logic [4:0]          r_cnt;
  op_t                 r_op;
  reg_idx_t            r_rd;
  logic [TAG_W-1:0]    r_tag;
  logic                r_neg_q;   // Product or quotient negative
  logic                r_neg_r;   // Remainder takes dividend sign
  logic [2*XLEN_W-1:0] r_acc;     // Product, or {remainder, quotient}
  logic [2*XLEN_W-1:0] r_opb;     // Shifted multiplicand, or divisor
  data_t               r_mplier;
  data_t               r_res;

  logic                w_is_mul;
  logic                w_a_neg;
  logic                w_b_neg;
  logic                w_div_zero;
  logic                w_div_ovf;
  logic                w_last;
  data_t               w_a_mag;
  data_t               w_b_mag;
  data_t               w_special;
  logic [2*XLEN_W-1:0] w_part;
  logic [2*XLEN_W-1:0] w_prod;
  logic [2*XLEN_W-1:0] w_prod_fix;
  logic [XLEN_W:0]     w_rem_sh;
  logic [XLEN_W:0]     w_trial;
  data_t               w_rem_next;
  data_t               w_quo_next;

  // ----------------------------------------------------------------------
  // Operand preparation
  // ----------------------------------------------------------------------
  assign w_is_mul   = i_op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  assign w_a_neg    = (i_op inside {OP_MULH, OP_MULHSU, OP_DIV, OP_REM}) & i_rs1[XLEN_W-1];
  assign w_b_neg    = (i_op inside {OP_MULH, OP_DIV, OP_REM}) & i_rs2[XLEN_W-1];
  assign w_a_mag    = w_a_neg ? -i_rs1 : i_rs1;
  assign w_b_mag    = w_b_neg ? -i_rs2 : i_rs2;
  assign w_div_zero = ~w_is_mul & (i_rs2 == '0);
  assign w_div_ovf  = (i_op inside {OP_DIV, OP_REM}) & (&i_rs2) &
                      (i_rs1 == {1'b1, {(XLEN_W-1){1'b0}}});
  assign w_special  = w_div_zero ? ((i_op inside {OP_DIV, OP_DIVU}) ? '1 : i_rs1) :
                      (i_op == OP_DIV) ? i_rs1 : '0;

  // Shift-and-add over one byte of the multiplier
  always_comb begin
    w_part = '0;
    for (int i = 0; i < MUL_UNROLL; i++) begin
      if (r_mplier[i]) begin
        w_part = w_part + (r_opb << i);
      end
    end
  end
  assign w_prod     = r_acc + w_part;
  assign w_prod_fix = r_neg_q ? -w_prod : w_prod;

  // One restoring step
  assign w_rem_sh   = {r_acc[2*XLEN_W-1:XLEN_W], r_acc[XLEN_W-1]};
  assign w_trial    = w_rem_sh - {1'b0, r_opb[XLEN_W-1:0]};
  assign w_rem_next = w_trial[XLEN_W] ? w_rem_sh[XLEN_W-1:0] : w_trial[XLEN_W-1:0];
  assign w_quo_next = {r_acc[XLEN_W-2:0], ~w_trial[XLEN_W]};

  assign w_last = (r_state == ST_MUL) ? (r_cnt == 5'(XLEN_W / MUL_UNROLL - 1)) :
                                        (r_cnt == 5'(XLEN_W - 1));

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ST_IDLE;
      r_cnt   <= '0;
    end else begin
      case (r_state)
        ST_MUL, ST_DIV: begin
          r_cnt <= r_cnt + 5'd1;
          if (w_last) begin
            r_state <= ST_DONE;
          end
        end
        default: begin   // DONE lasts one cycle
          r_cnt <= '0;
          if (!i_valid) begin
            r_state <= ST_IDLE;
          end else if (w_div_zero || w_div_ovf) begin
            r_state <= ST_DONE;
          end else begin
            r_state <= w_is_mul ? ST_MUL : ST_DIV;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && !o_busy) begin
      r_op    <= i_op;
      r_rd    <= i_rd;
      r_tag   <= i_tag;
      r_neg_q <= w_a_neg ^ w_b_neg;
      r_neg_r <= w_a_neg;
      r_res   <= w_special;
      r_acc   <= w_is_mul ? '0 : {{XLEN_W{1'b0}}, w_a_mag};
      r_opb   <= {{XLEN_W{1'b0}}, w_is_mul ? w_a_mag : w_b_mag};
      r_mplier <= w_b_mag;
    end else if (r_state == ST_MUL) begin
      r_acc    <= w_prod;
      r_opb    <= r_opb << MUL_UNROLL;
      r_mplier <= r_mplier >> MUL_UNROLL;
      if (w_last) begin
        r_res <= (r_op == OP_MUL) ? w_prod_fix[XLEN_W-1:0] : w_prod_fix[2*XLEN_W-1:XLEN_W];
      end
    end else if (r_state == ST_DIV) begin
      r_acc <= {w_rem_next, w_quo_next};
      if (w_last) begin
        r_res <= (r_op inside {OP_DIV, OP_DIVU}) ? (r_neg_q ? -w_quo_next : w_quo_next) :
                                                   (r_neg_r ? -w_rem_next : w_rem_next);
      end
    end
  end

  assign o_busy = (r_state == ST_MUL) || (r_state == ST_DIV);

  always_comb begin
    o_wb.valid = (r_state == ST_DONE);
    o_wb.rd    = r_rd;
    o_wb.data  = r_res;
    o_wb.tag   = r_tag;
  end

  // Upstream stall must hold launches off a running operation
  a_no_launch_busy: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_valid && o_busy));

endmodule

`default_nettype wire

// ==== rtl/int_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module int_regfile (
  input  wire logic                i_clk,
  input  wire logic                i_reset_n,
  input  wire riscv_pkg::reg_idx_t i_rd_addr1,
  input  wire riscv_pkg::reg_idx_t i_rd_addr2,
  output riscv_pkg::data_t         o_rd_data1,
  output riscv_pkg::data_t         o_rd_data2,
  input  wire exec_pkg::wb_t       i_wb
);
  import riscv_pkg::*;

  data_t r_regs [1:31];   // x0 has no storage

  function automatic data_t read_port(input reg_idx_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (i_wb.valid && i_wb.rd == addr) begin
      return i_wb.data;   // Same-cycle write wins
    end
    return r_regs[addr];
  endfunction

  always_comb begin
    o_rd_data1 = read_port(i_rd_addr1);
    o_rd_data2 = read_port(i_rd_addr2);
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 1; i < 32; i++) begin
        r_regs[i] <= '0;
      end
    end else if (i_wb.valid && i_wb.rd != '0) begin
      r_regs[i_wb.rd] <= i_wb.data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/alu_ctrl_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_ctrl_decoder (
  input  wire riscv_pkg::inst_t i_inst,
  output exec_pkg::op_t         o_op,
  output exec_pkg::imm_t        o_imm
);
  import riscv_pkg::*;
  import exec_pkg::*;

  logic [6:0] w_f7;
  logic [2:0] w_f3;

  assign w_f7 = i_inst.r.funct7;
  assign w_f3 = i_inst.r.funct3;

  // Shared by OP and OP-IMM
  function automatic op_t base_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? OP_SUB : OP_ADD;
      3'd1:    return OP_SLL;
      3'd2:    return OP_SLT;
      3'd3:    return OP_SLTU;
      3'd4:    return OP_XOR;
      3'd5:    return alt ? OP_SRA : OP_SRL;
      3'd6:    return OP_OR;
      default: return OP_AND;
    endcase
  endfunction

  always_comb begin
    o_op  = OP_NOP;
    o_imm = IMM_NONE;
    if (i_inst.u.opcode == OPC_LUI) begin
      o_op = OP_LUI;
    end else if (i_inst.u.opcode == OPC_AUIPC) begin
      o_op = OP_AUIPC;
    end else if (i_inst.r.opcode == OPC_OP) begin
      if (w_f7 == F7_BASE) begin
        o_op = base_op(w_f3, 1'b0);
      end else if (w_f7 == F7_ALT && (w_f3 == 3'd0 || w_f3 == 3'd5)) begin
        o_op = base_op(w_f3, 1'b1);
      end else if (w_f7 == F7_MULDIV) begin
        o_op = op_t'(OP_MUL + w_f3);
      end
    end else if (i_inst.r.opcode == OPC_OP_IMM) begin
      if (w_f3 == 3'd1) begin
        if (w_f7 == F7_BASE) begin
          o_op  = OP_SLL;
          o_imm = IMM_SH;
        end
      end else if (w_f3 == 3'd5) begin
        if (w_f7 == F7_BASE || w_f7 == F7_ALT) begin
          o_op  = base_op(w_f3, w_f7 == F7_ALT);
          o_imm = IMM_SH;
        end
      end else begin
        o_op  = base_op(w_f3, 1'b0);   // No SUBI
        o_imm = IMM_I;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

  localparam int TAG_W      = 4;
  localparam int MUL_UNROLL = 8;   // Multiplier bits per cycle

  // ----------------------------------------------------------------------
  // Operations
  // ----------------------------------------------------------------------
  // MUL to REMU follow funct3 order
  typedef enum logic [4:0] {
    OP_ADD,
    OP_SUB,
    OP_SLL,
    OP_SLT,
    OP_SLTU,
    OP_XOR,
    OP_SRL,
    OP_SRA,
    OP_OR,
    OP_AND,
    OP_LUI,
    OP_AUIPC,
    OP_MUL,
    OP_MULH,
    OP_MULHSU,
    OP_MULHU,
    OP_DIV,
    OP_DIVU,
    OP_REM,
    OP_REMU,
    OP_NOP
  } op_t;

  typedef enum logic [1:0] {
    IMM_NONE,
    IMM_I,     // Sign-extended 12 bits
    IMM_SH     // 5-bit shift amount
  } imm_t;

  // ----------------------------------------------------------------------
  // Buses
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic             valid;
    riscv_pkg::inst_t inst;
    riscv_pkg::pc_t   pc;
    logic [TAG_W-1:0] tag;
  } issue_t;

  typedef struct packed {
    logic                valid;
    riscv_pkg::reg_idx_t rd;
    riscv_pkg::data_t    data;
    logic [TAG_W-1:0]    tag;
  } wb_t;

endpackage

`default_nettype wire

// ==== rtl/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

  localparam int XLEN_W = 32;

  typedef logic [XLEN_W-1:0] data_t;
  typedef logic [XLEN_W-1:0] pc_t;
  typedef logic [4:0]        reg_idx_t;

  // Major opcodes handled by the integer pipe
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_ALT     = 7'b0100000;  // SUB, SRA
  localparam logic [6:0] F7_MULDIV  = 7'b0000001;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef union packed {
    r_type_t r;
    u_type_t u;
  } inst_t;

endpackage

`default_nettype wire
